/* vlog.f */
+incdir+logic
logic/cpu_pkg.sv
logic/dcache_pkg.sv
logic/dcache_if.sv
logic/pipe_reg.sv
logic/mem_ctrl.sv
logic/dcache_ways.sv
logic/mem_stage.sv
verif/tb_clk_gen.sv
verif/tb_mem_stage.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ns
TOP       = tb_mem_stage
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf $(OBJ_DIR)

/* verif/mem_stage_tests.txt */
# en op wr_data addr exp_out exp_miss_align, all fields in hex, x gives random wr_data
# op codes 0 NOP 1 LW 2 LH 3 LHU 4 LB 5 LBU 6 SW 7 SH 8 SB
1 1 x 00000100 00000000 0
1 6 12345678 00000100 00000000 0
1 1 x 00000100 12345678 0
1 8 000000aa 00000101 00000000 0
1 8 000000bb 00000103 00000000 0
1 7 0000cccc 00000102 00000000 0
1 1 x 00000100 ccccaa78 0
1 6 a5a5a5a5 00000200 00000000 0
1 8 00000011 00000200 00000000 0
1 8 00000022 00000202 00000000 0
1 7 00003333 00000200 00000000 0
1 1 x 00000200 a5223333 0
1 4 x 00000100 00000078 0
1 4 x 00000101 ffffffaa 0
1 5 x 00000102 000000cc 0
1 4 x 00000103 ffffffcc 0
1 5 x 00000101 000000aa 0
1 2 x 00000100 ffffaa78 0
1 3 x 00000102 0000cccc 0
1 2 x 00000102 ffffcccc 0
1 1 x 00000101 00000000 1
1 1 x 00000102 00000000 1
1 1 x 00000103 00000000 1
1 6 deadbeef 00000102 00000000 1
1 2 x 00000101 00000000 1
1 3 x 00000103 00000000 1
1 7 0000beef 00000101 00000000 1
1 7 0000beef 00000103 00000000 1
1 1 x 00000100 ccccaa78 0
1 0 x 12345678 12345678 0
0 1 x 00000100 00000000 0
1 1 x 00000300 00000000 0
1 1 x 00000200 00000000 0

/* verif/tb_mem_stage.sv */
`timescale 1ns/1ns

module tb_mem_stage;

    localparam int MAX_TESTS = 64;
    localparam int LATENCY   = 2;           // EX/MEM plus MEM/WB register

    logic             clk;
    logic             rst_n;
    logic             ex_en;
    cpu_pkg::mem_op_t ex_mem_op;
    logic [31:0]      ex_mem_wr_data;
    logic [31:0]      ex_out;
    logic             wb_en;
    logic [31:0]      wb_out;
    logic             wb_miss_align;

    logic             vec_en   [MAX_TESTS];
    logic [3:0]       vec_op   [MAX_TESTS];
    logic [31:0]      vec_wr   [MAX_TESTS];
    logic [31:0]      vec_addr [MAX_TESTS];
    logic [31:0]      vec_out  [MAX_TESTS];
    logic             vec_ma   [MAX_TESTS];
    logic [33:0]      exp_q [$];            // {en, out, miss_align} in flight

    int               n_tests = 0;
    int               errors  = 0;
    int               n_pass  = 0;
    int               n_fail  = 0;
    logic             loaded  = 1'b0;

    tb_clk_gen i_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mem_stage i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .ex_en          (ex_en),
        .ex_mem_op      (ex_mem_op),
        .ex_mem_wr_data (ex_mem_wr_data),
        .ex_out         (ex_out),
        .wb_en          (wb_en),
        .wb_out         (wb_out),
        .wb_miss_align  (wb_miss_align)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error %s got %h exp %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic load_tests();
        int          fd;
        int          cnt;
        string       line;
        logic [63:0] wr_tok;
        logic [31:0] wr_val;
        fd = $fopen("verif/mem_stage_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test vector file");
            errors++;
            return;
        end
        while (!$feof(fd) && n_tests < MAX_TESTS) begin
            line = "";
            cnt  = $fgets(line, fd);
            if (line.len() > 1 && line[0] != "#") begin     // Skip header and blank lines
                cnt = $sscanf(line, "%h %h %s %h %h %h", vec_en[n_tests], vec_op[n_tests],
                              wr_tok, vec_addr[n_tests], vec_out[n_tests], vec_ma[n_tests]);
                if (cnt != 6) begin
                    $display("Malformed test vector line, %0d fields read", cnt);
                    errors++;
                end
                if (wr_tok == "x") begin
                    wr_val = $urandom;                      // Don't care store data
                end else begin
                    cnt = $sscanf(wr_tok, "%h", wr_val);
                end
                vec_wr[n_tests] = wr_val;
                n_tests++;
            end
        end
        $fclose(fd);
    endtask

    // Outputs of one entry two edges after it was driven
    task automatic check_test(input int num, input logic [33:0] exp_v);
        int err_before;
        err_before = errors;
        if (exp_v[33] == 1'b1) begin
            check_value("wb_en", {31'h0, wb_en}, 32'h1);
            check_value("wb_out", wb_out, exp_v[32:1]);
            check_value("wb_miss_align", {31'h0, wb_miss_align}, {31'h0, exp_v[0]});
        end else begin
            check_value("wb_en", {31'h0, wb_en}, 32'h0);    // Idle entry
        end
        if (errors == err_before) begin
            n_pass++;
            $display("Test %0d op %0d addr %h passed", num, vec_op[num], vec_addr[num]);
        end else begin
            n_fail++;
            $display("Test %0d op %0d addr %h failed", num, vec_op[num], vec_addr[num]);
        end
    endtask

    initial begin
        logic [33:0] exp_v;
        ex_en          = 1'b0;
        ex_mem_op      = cpu_pkg::NOP;
        ex_mem_wr_data = '0;
        ex_out         = '0;
        void'($urandom(32'h9576002f));
        load_tests();
        loaded = 1'b1;
        wait (rst_n == 1'b1);
        for (int idx = 0; idx < n_tests + LATENCY; idx++) begin
            @(posedge clk);
            #2;
            if (idx >= LATENCY) begin
                exp_v = exp_q.pop_front();
                check_test(idx - LATENCY, exp_v);
            end
            if (idx < n_tests) begin
                ex_en          = vec_en[idx];
                ex_mem_op      = cpu_pkg::mem_op_t'(vec_op[idx]);
                ex_mem_wr_data = vec_wr[idx];
                ex_out         = vec_addr[idx];
                exp_q.push_back({vec_en[idx], vec_out[idx], vec_ma[idx]});
            end else begin
                ex_en = 1'b0;                               // Drain the pipeline
            end
        end
        $display("Tests passed %0d failed %0d errors %0d", n_pass, n_fail, errors);
        if (errors == 0 && n_tests > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        wait (loaded == 1'b1);
        #((n_tests + 10) * 20);
        $display("Run timed out before all tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #2 rst_n = 1'b1;                    // Released at the stimulus offset
    end

    always #10 clk = ~clk;                  // 20 ns period

endmodule

/* logic/mem_stage.sv */
`timescale 1ns/1ns

`include "mem_macros.svh"

module mem_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ex_en,
    input  cpu_pkg::mem_op_t     ex_mem_op,
    input  logic [`WORD_W-1:0]   ex_mem_wr_data,
    input  logic [`WORD_W-1:0]   ex_out,
    output logic                 wb_en,
    output logic [`WORD_W-1:0]   wb_out,
    output logic                 wb_miss_align
);

    cpu_pkg::ex_mem_t ex_d;
    cpu_pkg::ex_mem_t ex_q;
    cpu_pkg::mem_wb_t mem_res;
    cpu_pkg::mem_wb_t wb_q;

    dcache_if dc_bus ();

    assign ex_d.en      = ex_en;
    assign ex_d.mem_op  = ex_mem_op;
    assign ex_d.wr_data = ex_mem_wr_data;
    assign ex_d.ex_out  = ex_out;

    pipe_reg #(.payload_t(cpu_pkg::ex_mem_t)) i_ex_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .d     (ex_d),
        .q     (ex_q)
    );

    mem_ctrl i_mem_ctrl (
        .ex  (ex_q),
        .dc  (dc_bus.ctrl),
        .res (mem_res)
    );

    dcache_ways i_dcache (
        .clk   (clk),
        .rst_n (rst_n),
        .dc    (dc_bus.array)
    );

    // Write into the cache lands on the same edge as this capture
    pipe_reg #(.payload_t(cpu_pkg::mem_wb_t)) i_mem_wb (
        .clk   (clk),
        .rst_n (rst_n),
        .d     (mem_res),
        .q     (wb_q)
    );

    assign wb_en         = wb_q.en;
    assign wb_out        = wb_q.out;
    assign wb_miss_align = wb_q.miss_align;

endmodule

/* logic/dcache_ways.sv */
`timescale 1ns/1ns

`include "mem_macros.svh"

module dcache_ways (
    input  logic     clk,
    input  logic     rst_n,
    dcache_if.array  dc
);

    dcache_pkg::tag_t      tags  [2][`SETS];
    dcache_pkg::line_t     lines [2][`SETS];
    logic [`SETS-1:0]      valid [2];
    logic [`SETS-1:0]      lru;                 // Points at the way to replace

    dcache_pkg::index_t    idx;
    dcache_pkg::tag_t      tag;
    dcache_pkg::word_sel_t word_sel;
    logic [1:0]            hit;
    logic                  hit_way;
    dcache_pkg::line_t     sel_line;
    dcache_pkg::line_t     new_line;

    assign idx      = dc.addr[5:4];
    assign tag      = dc.addr[31:6];
    assign word_sel = dc.addr[3:2];

    assign hit[`WAY0] = valid[`WAY0][idx] && (tags[`WAY0][idx] == tag);
    assign hit[`WAY1] = valid[`WAY1][idx] && (tags[`WAY1][idx] == tag);

    // Miss falls back to the LRU way, which gets allocated
    assign hit_way = hit[`WAY1] ? `WAY1 : (hit[`WAY0] ? `WAY0 : lru[idx]);

    assign dc.hitway   = hit_way;
    assign dc.data0_rd = hit[`WAY0] ? lines[`WAY0][idx] : '0;
    assign dc.data1_rd = hit[`WAY1] ? lines[`WAY1][idx] : '0;

    assign sel_line     = hit[`WAY1] ? lines[`WAY1][idx] : (hit[`WAY0] ? lines[`WAY0][idx] : '0);
    assign dc.read_data = sel_line[word_sel];

    // Zero-filled line on a miss, then the store word on top
    always_comb begin
        new_line = sel_line;
        if (dc.rw == `WRITE) begin
            new_line[word_sel] = dc.wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid[`WAY0] <= '0;
            valid[`WAY1] <= '0;
            lru          <= '0;
        end else if (dc.req == `ENABLE) begin
            lru[idx] <= ~hit_way;               // Other way becomes LRU
            if (hit == 2'b00) begin
                valid[hit_way][idx] <= `ENABLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dc.req == `ENABLE) begin
            if ((hit == 2'b00) || (dc.rw == `WRITE)) begin
                lines[hit_way][idx] <= new_line;
            end
            if (hit == 2'b00) begin
                tags[hit_way][idx] <= tag;      // Evicted line is dropped
            end
        end
    end

endmodule

/* logic/mem_ctrl.sv */
`timescale 1ns/1ns

`include "mem_macros.svh"

module mem_ctrl (
    input  cpu_pkg::ex_mem_t ex,
    dcache_if.ctrl           dc,
    output cpu_pkg::mem_wb_t res
);

    logic [`BYTE_OFFSET_W-1:0] offset;
    dcache_pkg::word_sel_t     word_sel;
    logic [`WORD_W-1:0]        cur_word;
    logic [7:0]                ld_byte;
    logic [15:0]               ld_half;

    assign dc.addr  = ex.ex_out;
    assign offset   = ex.ex_out[`BYTE_OFFSET_W-1:0];
    assign word_sel = ex.ex_out[3:2];

    // Current contents of the target word in the hit way, zero on miss
    assign cur_word = (dc.hitway == `WAY1) ? dc.data1_rd[word_sel] : dc.data0_rd[word_sel];

    assign ld_half = offset[1] ? dc.read_data[31:16] : dc.read_data[15:0];

    always_comb begin
        case (offset)
            `BYTE0: ld_byte = dc.read_data[7:0];
            `BYTE1: ld_byte = dc.read_data[15:8];
            `BYTE2: ld_byte = dc.read_data[23:16];
            `BYTE3: ld_byte = dc.read_data[31:24];
        endcase
    end

    always_comb begin
        res.en         = ex.en;
        res.out        = '0;
        res.miss_align = `DISABLE;
        dc.req         = `DISABLE;
        dc.rw          = `READ;
        dc.wr_data     = ex.wr_data;
        if (ex.en == `ENABLE) begin
            case (ex.mem_op)
                cpu_pkg::LW: begin
                    if (offset == `BYTE0) begin
                        dc.req  = `ENABLE;
                        res.out = dc.read_data;
                    end else begin
                        res.miss_align = `ENABLE;
                    end
                end
                cpu_pkg::LH, cpu_pkg::LHU: begin
                    if (offset[0] == 1'b0) begin
                        dc.req = `ENABLE;
                        if (ex.mem_op == cpu_pkg::LH) begin
                            res.out = {{16{ld_half[15]}}, ld_half};     // Sign extend
                        end else begin
                            res.out = {16'h0, ld_half};
                        end
                    end else begin
                        res.miss_align = `ENABLE;
                    end
                end
                cpu_pkg::LB: begin
                    dc.req  = `ENABLE;
                    res.out = {{24{ld_byte[7]}}, ld_byte};
                end
                cpu_pkg::LBU: begin
                    dc.req  = `ENABLE;
                    res.out = {24'h0, ld_byte};
                end
                cpu_pkg::SW: begin
                    if (offset == `BYTE0) begin
                        dc.req = `ENABLE;
                        dc.rw  = `WRITE;
                    end else begin
                        res.miss_align = `ENABLE;                       // Store dropped
                    end
                end
                cpu_pkg::SH: begin
                    if (offset[0] == 1'b0) begin
                        dc.req = `ENABLE;
                        dc.rw  = `WRITE;
                        if (offset[1] == 1'b0) begin
                            dc.wr_data = {cur_word[31:16], ex.wr_data[15:0]};
                        end else begin
                            dc.wr_data = {ex.wr_data[15:0], cur_word[15:0]};
                        end
                    end else begin
                        res.miss_align = `ENABLE;
                    end
                end
                cpu_pkg::SB: begin
                    dc.req     = `ENABLE;
                    dc.rw      = `WRITE;
                    dc.wr_data = cur_word;
                    dc.wr_data[{offset, 3'b000} +: 8] = ex.wr_data[7:0];   // New byte in place
                end
                default: begin
                    res.out = ex.ex_out;                                // NOP
                end
            endcase
        end
    end

endmodule

/* logic/pipe_reg.sv */
`timescale 1ns/1ns

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t d,
    output payload_t q
);

    // Whole payload cleared on reset so the entry enable drops too
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q <= '0;
        end else begin
            q <= d;                         // No stall, load every cycle
        end
    end

endmodule

/* logic/dcache_if.sv */
`timescale 1ns/1ns

`include "mem_macros.svh"

interface dcache_if;

    logic                  req;             // Access strobe
    logic [`WORD_W-1:0]    addr;
    logic                  rw;              // READ or WRITE
    logic [`WORD_W-1:0]    wr_data;         // Already merged word
    logic [`WORD_W-1:0]    read_data;       // Word at addr, zero on miss
    logic                  hitway;          // Hit way, or LRU way on miss
    dcache_pkg::line_t     data0_rd;        // Way 0 line when it hits
    dcache_pkg::line_t     data1_rd;        // Way 1 line when it hits

    modport ctrl (
        output req, addr, rw, wr_data,
        input  read_data, hitway, data0_rd, data1_rd
    );

    modport array (
        input  req, addr, rw, wr_data,
        output read_data, hitway, data0_rd, data1_rd
    );

endinterface

/* logic/dcache_pkg.sv */
`include "mem_macros.svh"

package dcache_pkg;

    // One cache line, word 0 in the low bits
    typedef logic [`WORDS_PER_LINE-1:0][`WORD_W-1:0] line_t;

    typedef logic [1:0]  index_t;           // Address bits 5:4
    typedef logic [25:0] tag_t;             // Address bits 31:6
    typedef logic [1:0]  word_sel_t;        // Address bits 3:2

endpackage

/* logic/cpu_pkg.sv */
`include "mem_macros.svh"

package cpu_pkg;

    // Memory operation carried from EX into MEM
    typedef enum logic [3:0] {
        NOP = 4'd0,                         // Pass EX result through
        LW  = 4'd1,
        LH  = 4'd2,
        LHU = 4'd3,
        LB  = 4'd4,
        LBU = 4'd5,
        SW  = 4'd6,
        SH  = 4'd7,
        SB  = 4'd8
    } mem_op_t;

    typedef struct packed {
        logic                 en;           // Entry valid
        mem_op_t              mem_op;
        logic [`WORD_W-1:0]   wr_data;      // Store data
        logic [`WORD_W-1:0]   ex_out;       // Address or ALU result
    } ex_mem_t;

    typedef struct packed {
        logic                 en;
        logic [`WORD_W-1:0]   out;          // Load data or passed result
        logic                 miss_align;
    } mem_wb_t;

endpackage

/* logic/mem_macros.svh */
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

`define WORD_W          32      // Data word width
`define SETS            4       // Cache sets
`define WORDS_PER_LINE  4       // Words in one cache line
`define BYTE_OFFSET_W   2       // Byte offset within a word

`define ENABLE          1'b1
`define DISABLE         1'b0
`define READ            1'b0
`define WRITE           1'b1
`define WAY0            1'b0
`define WAY1            1'b1
`define BYTE0           2'd0
`define BYTE1           2'd1
`define BYTE2           2'd2
`define BYTE3           2'd3

`endif
